// ==== Makefile ====
# Verilator build and run for the l1 cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# a missing pass line (crash, early stop) also counts as failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== block_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block word counter and flush walk counter
// word count for fill/evict, set+word walk for flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module block_counter import cache_pkg::*; (
    input  wire logic                  CLK,
    input  wire logic                  nRST,
    input  count_ctrl_t                cnt_ctrl,
    output logic [BLOCK_BITS-1:0]      word_idx,
    output logic                       word_last,
    output logic [SET_BITS-1:0]        flush_set,
    output logic [BLOCK_BITS-1:0]      flush_word,
    output logic                       flush_finish
);

    typedef struct packed {
        logic                  finish;  // carry out of the set field
        logic [SET_BITS-1:0]   set;
        logic [BLOCK_BITS-1:0] word;
    } walk_t;

    logic [BLOCK_BITS-1:0] word_cnt;
    walk_t                 walk;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            word_cnt <= '0;
        else if (cnt_ctrl.word_clr)
            word_cnt <= '0;
        else if (cnt_ctrl.word_inc)
            word_cnt <= word_cnt + 1'b1;
    end

    // step with word_inc walks one word, alone it skips to the next set
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            walk <= '0;
        end else if (cnt_ctrl.flush_clr) begin
            walk <= '0;
        end else if (cnt_ctrl.flush_step) begin
            if (cnt_ctrl.word_inc)
                walk <= walk + 1'b1;    // last word carries into set
            else
                walk <= {{walk.finish, walk.set} + 1'b1, BLOCK_BITS'(0)};
        end
    end

    assign word_idx     = word_cnt;
    assign word_last    = (word_cnt == BLOCK_BITS'(BLOCK_WORDS - 1));
    assign flush_set    = walk.set;
    assign flush_word   = walk.word;
    assign flush_finish = walk.finish;

    // flush writeback moves both counters in lockstep
    a_walk_in_step: assert property (@(posedge CLK) disable iff (!nRST)
        (cnt_ctrl.flush_step && cnt_ctrl.word_inc) |-> word_cnt == walk.word);

endmodule

`default_nettype wire

// ==== cache_array.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache frame storage, one frame per set
// combinational read, bit-masked write at the clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_array import cache_pkg::*; (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire logic [SET_BITS-1:0] index,
    input  wire logic                wen,
    input  cache_frame_t             wr_frame,
    input  cache_frame_t             wr_mask,
    output cache_frame_t             rd_frame
);

    cache_frame_t         frames [N_SETS];   // tag and data live here
    logic [N_SETS-1:0]    valid_q;
    logic [N_SETS-1:0]    dirty_q;

    // status bits are kept apart so reset can clear them
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wen) begin
            if (wr_mask.valid)
                valid_q[index] <= wr_frame.valid;
            if (wr_mask.dirty)
                dirty_q[index] <= wr_frame.dirty;
        end
    end

    always_ff @(posedge CLK) begin
        if (wen)
            frames[index] <= (frames[index] & ~wr_mask) | (wr_frame & wr_mask);
    end

    always_comb begin
        rd_frame       = frames[index];
        rd_frame.valid = valid_q[index];
        rd_frame.dirty = dirty_q[index];
    end

endmodule

`default_nettype wire

// ==== cache_datapath.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache datapath
// hit check, byte merge, fill/evict/flush writes, memory requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_datapath import cache_pkg::*; (
    input  wire logic                  CLK,
    input  wire logic                  nRST,
    input  bus_req_t                   core_req,
    input  bus_rsp_t                   mem_rsp,
    input  dp_ctrl_t                   dp_ctrl,
    input  wire logic [BLOCK_BITS-1:0] word_idx,
    input  wire logic [SET_BITS-1:0]   flush_set,
    input  wire logic [BLOCK_BITS-1:0] flush_word,
    input  cache_frame_t               rd_frame,
    output word_t                      core_rdata,
    output logic                       hit,
    output logic                       victim_dirty,
    output logic                       frame_dirty,
    output bus_req_t                   mem_req,
    output logic [SET_BITS-1:0]        arr_index,
    output logic                       arr_wen,
    output cache_frame_t               wr_frame,
    output cache_frame_t               wr_mask
);

    cache_addr_u req_addr;  // live core address
    cache_addr_u cap_addr;  // address held over a miss
    cache_addr_u mem_addr;
    logic        miss_op;
    logic        walk_op;
    logic        frame_vd;

    assign req_addr.raw = core_req.addr;
    assign miss_op      = (dp_ctrl.op == OP_FETCH) || (dp_ctrl.op == OP_EVICT);
    assign walk_op      = (dp_ctrl.op == OP_FLUSH_WB) || (dp_ctrl.op == OP_FLUSH_CLEAR);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            cap_addr.raw <= '0;
        else if (!miss_op && !walk_op)
            cap_addr.raw <= core_req.addr;
    end

    always_comb begin
        if (walk_op)
            arr_index = flush_set;
        else if (miss_op)
            arr_index = cap_addr.f.set;
        else
            arr_index = req_addr.f.set;
    end

    assign frame_vd     = rd_frame.valid && rd_frame.dirty;
    assign hit          = rd_frame.valid && (rd_frame.tag == req_addr.f.tag);
    assign victim_dirty = frame_vd;     // indexed by the core set in idle
    assign frame_dirty  = frame_vd;     // indexed by the walk in flush
    assign core_rdata   = rd_frame.data[req_addr.f.word];

    always_comb begin
        arr_wen          = 1'b0;
        wr_frame         = '0;
        wr_mask          = '0;
        mem_req          = '0;
        mem_req.byte_en  = '1;          // whole words toward memory
        mem_addr.raw     = '0;

        case (dp_ctrl.op)
            OP_HIT_WRITE: begin
                arr_wen = hit;
                wr_frame.data[req_addr.f.word] = core_req.wdata;
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    if (core_req.byte_en[b])
                        wr_mask.data[req_addr.f.word][8*b +: 8] = 8'hFF;
                end
                wr_frame.dirty = 1'b1;
                wr_mask.dirty  = 1'b1;
            end
            OP_FETCH: begin
                mem_addr.f.tag  = cap_addr.f.tag;
                mem_addr.f.set  = cap_addr.f.set;
                mem_addr.f.word = word_idx;
                mem_req.ren     = 1'b1;
                mem_req.addr    = mem_addr.raw;
                arr_wen         = dp_ctrl.word_done;
                wr_frame.data[word_idx] = mem_rsp.rdata;
                wr_mask.data[word_idx]  = '1;
                if (dp_ctrl.block_done) begin
                    wr_frame.valid = 1'b1;  // tag and valid with the last word
                    wr_frame.tag   = cap_addr.f.tag;
                    wr_mask.valid  = 1'b1;
                    wr_mask.dirty  = 1'b1;
                    wr_mask.tag    = '1;
                end
            end
            OP_EVICT: begin
                mem_addr.f.tag  = rd_frame.tag;     // victim block
                mem_addr.f.set  = cap_addr.f.set;
                mem_addr.f.word = word_idx;
                mem_req.wen     = 1'b1;
                mem_req.addr    = mem_addr.raw;
                mem_req.wdata   = rd_frame.data[word_idx];
                arr_wen         = dp_ctrl.block_done;
                wr_mask.valid   = 1'b1;
                wr_mask.dirty   = 1'b1;
            end
            OP_FLUSH_WB, OP_FLUSH_CLEAR: begin
                wr_mask.valid = 1'b1;
                wr_mask.dirty = 1'b1;
                if (dp_ctrl.op == OP_FLUSH_WB && frame_vd) begin
                    mem_addr.f.tag  = rd_frame.tag;
                    mem_addr.f.set  = flush_set;
                    mem_addr.f.word = flush_word;
                    mem_req.wen     = 1'b1;
                    mem_req.addr    = mem_addr.raw;
                    mem_req.wdata   = rd_frame.data[flush_word];
                    arr_wen         = dp_ctrl.block_done;
                end else begin
                    arr_wen = 1'b1; // clean frame, just invalidate
                end
            end
            default: ;
        endcase
    end

    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(core_req.ren && core_req.wen));

endmodule

`default_nettype wire

// ==== cache_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache controller FSM
// picks the datapath op, steps the counters, holds flush requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_fsm import cache_pkg::*; (
    input  wire logic  CLK,
    input  wire logic  nRST,
    input  wire logic  flush,
    input  bus_req_t   core_req,
    input  bus_rsp_t   mem_rsp,
    input  wire logic  hit,
    input  wire logic  victim_dirty,
    input  wire logic  frame_dirty,
    input  wire logic  word_last,
    input  wire logic  flush_finish,
    output dp_ctrl_t   dp_ctrl,
    output count_ctrl_t cnt_ctrl,
    output logic       flush_done,
    output logic       core_busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_WB,
        S_FLUSH
    } state_e;

    state_e state, next_state;
    logic   flush_req;
    logic   flush_pend;

    assign flush_pend = flush | flush_req;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= S_IDLE;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (state == S_FLUSH)
                flush_req <= 1'b0;  // served
            else if (flush)
                flush_req <= 1'b1;
        end
    end

    always_comb begin
        next_state          = state;
        dp_ctrl.op          = OP_IDLE;
        dp_ctrl.word_done   = 1'b0;
        dp_ctrl.block_done  = 1'b0;
        cnt_ctrl            = '0;
        flush_done          = 1'b0;
        core_busy           = 1'b1;

        case (state)
            S_IDLE: begin
                if (flush_pend) begin
                    next_state = S_FLUSH;   // ahead of any miss
                end else if (core_req.ren || core_req.wen) begin
                    // op does not wait on hit, datapath qualifies the write
                    dp_ctrl.op = core_req.wen ? OP_HIT_WRITE : OP_HIT_READ;
                    if (hit)
                        core_busy = 1'b0;
                    else if (victim_dirty)
                        next_state = S_WB;
                    else
                        next_state = S_FETCH;
                    cnt_ctrl.word_clr = !hit;
                end
            end
            S_FETCH, S_WB: begin
                dp_ctrl.op         = (state == S_FETCH) ? OP_FETCH : OP_EVICT;
                dp_ctrl.word_done  = !mem_rsp.busy;
                dp_ctrl.block_done = !mem_rsp.busy && word_last;
                cnt_ctrl.word_inc  = dp_ctrl.word_done;
                cnt_ctrl.word_clr  = dp_ctrl.block_done;
                if (dp_ctrl.block_done)
                    next_state = (state == S_FETCH) ? S_IDLE : S_FETCH;
            end
            S_FLUSH: begin
                if (flush_finish) begin
                    dp_ctrl.op         = OP_FLUSH_CLEAR;
                    cnt_ctrl.flush_clr = 1'b1;
                    flush_done         = 1'b1;
                    next_state         = S_IDLE;
                end else begin
                    dp_ctrl.op = OP_FLUSH_WB;
                    if (frame_dirty) begin
                        dp_ctrl.word_done   = !mem_rsp.busy;
                        dp_ctrl.block_done  = !mem_rsp.busy && word_last;
                        cnt_ctrl.word_inc   = dp_ctrl.word_done;
                        cnt_ctrl.word_clr   = dp_ctrl.block_done;
                        cnt_ctrl.flush_step = dp_ctrl.word_done;
                    end else begin
                        cnt_ctrl.flush_step = 1'b1; // clean frame, skip the set
                    end
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    // the core keeps its request steady while it sees busy
    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        ((core_req.ren || core_req.wen) && core_busy) |=> $stable(core_req));

    // a finished fill hits on the request that caused it
    a_fill_hits: assert property (@(posedge CLK) disable iff (!nRST)
        (state == S_FETCH && dp_ctrl.block_done) |=> hit);

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l1 data cache package
// geometry, bus structs, frame and address types, control types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cache_pkg;

    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int BLOCK_WORDS    = 2;
    localparam int N_SETS         = 16;
    localparam int BLOCK_BITS     = $clog2(BLOCK_WORDS);
    localparam int SET_BITS       = $clog2(N_SETS);
    localparam int TAG_BITS       = WORD_W - SET_BITS - BLOCK_BITS - $clog2(BYTES_PER_WORD);

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   set;
        logic [BLOCK_BITS-1:0] word;
        logic [1:0]            byte_off;
    } addr_fields_t;

    // same word seen raw or split into fields
    typedef union packed {
        word_t        raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [TAG_BITS-1:0]        tag;
        word_t [BLOCK_WORDS-1:0]    data;
    } cache_frame_t;

    typedef struct packed {
        logic                      ren;
        logic                      wen;
        word_t                     addr;
        word_t                     wdata;
        logic [BYTES_PER_WORD-1:0] byte_en;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
        logic  busy;    // low marks completion
    } bus_rsp_t;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_HIT_READ,
        OP_HIT_WRITE,
        OP_FETCH,
        OP_EVICT,
        OP_FLUSH_WB,
        OP_FLUSH_CLEAR
    } cache_op_e;

    typedef struct packed {
        cache_op_e op;
        logic      word_done;   // memory finished this word
        logic      block_done;  // and it was the last one
    } dp_ctrl_t;

    typedef struct packed {
        logic word_inc;
        logic word_clr;
        logic flush_step;
        logic flush_clr;
    } count_ctrl_t;

endpackage

`default_nettype wire

// ==== l1_cache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l1 data cache top
// direct mapped, write back, write allocate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module l1_cache import cache_pkg::*; (
    input  wire logic CLK,
    input  wire logic nRST,
    input  wire logic flush,
    output logic      flush_done,
    input  bus_req_t  core_req,
    output bus_rsp_t  core_rsp,
    output bus_req_t  mem_req,
    input  bus_rsp_t  mem_rsp
);

    dp_ctrl_t              dp_ctrl;
    count_ctrl_t           cnt_ctrl;
    logic                  hit;
    logic                  victim_dirty;
    logic                  frame_dirty;
    logic [BLOCK_BITS-1:0] word_idx;
    logic                  word_last;
    logic [SET_BITS-1:0]   flush_set;
    logic [BLOCK_BITS-1:0] flush_word;
    logic                  flush_finish;
    logic [SET_BITS-1:0]   arr_index;
    logic                  arr_wen;
    cache_frame_t          wr_frame;
    cache_frame_t          wr_mask;
    cache_frame_t          rd_frame;

    cache_fsm i_cache_fsm (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .core_req     (core_req),
        .mem_rsp      (mem_rsp),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .frame_dirty  (frame_dirty),
        .word_last    (word_last),
        .flush_finish (flush_finish),
        .dp_ctrl      (dp_ctrl),
        .cnt_ctrl     (cnt_ctrl),
        .flush_done   (flush_done),
        .core_busy    (core_rsp.busy)
    );

    block_counter i_block_counter (
        .CLK          (CLK),
        .nRST         (nRST),
        .cnt_ctrl     (cnt_ctrl),
        .word_idx     (word_idx),
        .word_last    (word_last),
        .flush_set    (flush_set),
        .flush_word   (flush_word),
        .flush_finish (flush_finish)
    );

    cache_datapath i_cache_datapath (
        .CLK          (CLK),
        .nRST         (nRST),
        .core_req     (core_req),
        .mem_rsp      (mem_rsp),
        .dp_ctrl      (dp_ctrl),
        .word_idx     (word_idx),
        .flush_set    (flush_set),
        .flush_word   (flush_word),
        .rd_frame     (rd_frame),
        .core_rdata   (core_rsp.rdata),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .frame_dirty  (frame_dirty),
        .mem_req      (mem_req),
        .arr_index    (arr_index),
        .arr_wen      (arr_wen),
        .wr_frame     (wr_frame),
        .wr_mask      (wr_mask)
    );

    cache_array i_cache_array (
        .CLK      (CLK),
        .nRST     (nRST),
        .index    (arr_index),
        .wen      (arr_wen),
        .wr_frame (wr_frame),
        .wr_mask  (wr_mask),
        .rd_frame (rd_frame)
    );

endmodule

`default_nettype wire

// ==== tb_l1_cache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the l1 data cache
// directed tests and random traffic against a reference memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache import cache_pkg::*; ();

    localparam int    CLK_PERIOD = 10;
    localparam int    MEM_LAT    = 2;
    localparam int    MEM_WORDS  = 256;
    localparam word_t FILL_PAT   = 32'h5A3C_96E1;
    localparam int    TIMEOUT    = 400;     // cycles per wait
    localparam int    N_RANDOM   = 80;

    logic     CLK;
    logic     nRST;
    logic     flush;
    logic     flush_done;
    bus_req_t core_req;
    bus_rsp_t core_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;
    word_t    peek_addr;
    word_t    peek_data;
    word_t    ref_mem [MEM_WORDS];      // expected memory image
    int       n_tests;
    int       n_checks;
    int       n_errors;
    integer   seed;

    l1_cache i_l1_cache (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .core_req   (core_req),
        .core_rsp   (core_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    tb_mem_model #(.MEM_LAT(MEM_LAT), .MEM_WORDS(MEM_WORDS), .FILL_PAT(FILL_PAT)) i_mem (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD/2) CLK = ~CLK;
    end

    function automatic int word_index(input word_t addr);
        return int'(addr[9:2]);
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input logic [BYTES_PER_WORD-1:0] be);
        word_t res;
        res = old_w;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (be[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one core transfer; missed is busy in the request cycle
    task automatic core_access(input logic write, input word_t addr, input word_t wdata,
                               input logic [BYTES_PER_WORD-1:0] be,
                               output word_t rdata, output logic missed);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        core_req.ren     = !write;
        core_req.wen     = write;
        core_req.addr    = addr;
        core_req.wdata   = wdata;
        core_req.byte_en = be;
        #2;
        missed = core_rsp.busy;
        while (core_rsp.busy && cycles < TIMEOUT) begin
            @(negedge CLK);
            #2;
            cycles++;
        end
        rdata = core_rsp.rdata;     // completes at the coming edge
        if (core_rsp.busy) begin
            n_errors++;
            $display("timeout: core access to %h still busy after %0d cycles", addr, TIMEOUT);
        end
        @(negedge CLK);
        core_req = '0;
    endtask

    task automatic read_check(input word_t addr, output logic missed);
        word_t got;
        core_access(1'b0, addr, '0, '0, got, missed);
        compare_word($sformatf("read %h", addr), got, ref_mem[word_index(addr)]);
    endtask

    task automatic write_word(input word_t addr, input word_t data,
                              input logic [BYTES_PER_WORD-1:0] be);
        word_t rd_unused;
        logic  miss_unused;
        core_access(1'b1, addr, data, be, rd_unused, miss_unused);
        ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], data, be);
    endtask

    task automatic flush_cache();
        int cycles;
        cycles = 0;
        @(negedge CLK);
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        #2;
        while (!flush_done && cycles < TIMEOUT) begin
            @(negedge CLK);
            #2;
            cycles++;
        end
        n_checks++;
        if (!flush_done) begin
            n_errors++;
            $display("timeout: flush_done did not pulse within %0d cycles", TIMEOUT);
        end
        @(negedge CLK);
        #2;
        n_checks++;
        if (flush_done) begin
            n_errors++;
            $display("flush_done stayed high for more than one cycle");
        end
    endtask

    // whole memory against the reference, through the backdoor
    task automatic check_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            peek_addr = word_t'(i * BYTES_PER_WORD);
            #1;
            compare_word($sformatf("memory word %h", peek_addr), peek_data, ref_mem[i]);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        n_tests++;
        $display("test %s: %0d errors", name, n_errors - start_errors);
    endtask

    task automatic test_reset_read();
        int   start;
        logic missed;
        start = n_errors;
        @(negedge CLK);
        #2;
        n_checks++;
        if (!core_rsp.busy || flush_done || mem_req.ren || mem_req.wen) begin
            n_errors++;
            $display("error @%0t: after reset busy=%b flush_done=%b mem ren=%b wen=%b",
                     $time, core_rsp.busy, flush_done, mem_req.ren, mem_req.wen);
        end
        read_check(32'h040, missed);
        compare_word("first read missed", word_t'(missed), 32'd1);
        read_check(32'h040, missed);
        compare_word("second read missed", word_t'(missed), 32'd0);
        report_test("reset and read miss then hit", start);
    endtask

    task automatic test_byte_write();
        int   start;
        logic missed;
        start = n_errors;
        write_word(32'h020, 32'h1111_11AA, 4'b0001);   // write miss allocates first
        read_check(32'h020, missed);
        write_word(32'h020, 32'h22BB_CC22, 4'b0110);
        read_check(32'h020, missed);
        write_word(32'h020, 32'h3344_5566, 4'b1111);
        read_check(32'h020, missed);
        report_test("byte masked write hit", start);
    endtask

    task automatic test_eviction();
        int    start;
        logic  missed;
        word_t mem_word;
        start = n_errors;
        write_word(32'h010, 32'hDEAD_BEEF, 4'b1111);
        read_check(32'h090, missed);    // same set, other tag
        peek_addr = 32'h010;
        #1;
        mem_word = peek_data;
        compare_word("written back word 010", mem_word, ref_mem[word_index(32'h010)]);
        report_test("dirty eviction", start);
    endtask

    task automatic test_flush();
        int   start;
        logic missed;
        start = n_errors;
        write_word(32'h100, 32'hCAFE_0001, 4'b1111);
        write_word(32'h12C, 32'hCAFE_0002, 4'b1111);
        write_word(32'h1F8, 32'h0BAD_F00D, 4'b1100);
        flush_cache();
        check_memory();
        read_check(32'h12C, missed);
        compare_word("read after flush missed", word_t'(missed), 32'd1);
        report_test("flush", start);
    endtask

    task automatic test_random();
        int    start;
        logic  missed;
        word_t r;
        word_t addr;
        word_t data;
        start = n_errors;
        for (int n = 0; n < N_RANDOM; n++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = r & 32'h0000_01FC;   // four tags per set
            if (r[31])
                write_word(addr, data, r[27:24]);
            else
                read_check(addr, missed);
        end
        flush_cache();
        check_memory();
        report_test("random traffic", start);
    endtask

    initial begin
        nRST      = 1'b0;
        flush     = 1'b0;
        core_req  = '0;
        peek_addr = '0;
        n_tests   = 0;
        n_checks  = 0;
        n_errors  = 0;
        seed      = 2;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = word_t'(i * BYTES_PER_WORD) ^ FILL_PAT;   // address xor pattern
        repeat (5) @(negedge CLK);
        nRST = 1'b1;

        test_reset_read();
        test_byte_write();
        test_eviction();
        test_flush();
        test_random();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral word memory for the cache testbench
// fixed busy latency per word, backdoor read port for checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import cache_pkg::*; #(
    parameter int    MEM_LAT   = 2,
    parameter int    MEM_WORDS = 256,
    parameter word_t FILL_PAT  = 32'h0
) (
    input  wire logic CLK,
    input  wire logic nRST,
    input  bus_req_t  mem_req,
    output bus_rsp_t  mem_rsp,
    input  word_t     peek_addr,
    output word_t     peek_data
);

    localparam int IDX_BITS = $clog2(MEM_WORDS);

    word_t               mem [MEM_WORDS];
    logic [7:0]          wait_cnt;      // busy cycles spent on this word
    logic [IDX_BITS-1:0] idx;
    logic                active;
    logic                done;

    assign idx    = mem_req.addr[IDX_BITS+1:2];
    assign active = mem_req.ren || mem_req.wen;
    assign done   = active && (wait_cnt == 8'(MEM_LAT));

    assign mem_rsp.busy  = !done;
    assign mem_rsp.rdata = done ? mem[idx] : '0;
    assign peek_data     = mem[peek_addr[IDX_BITS+1:2]];   // backdoor

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= word_t'(i * BYTES_PER_WORD) ^ FILL_PAT;
        end else begin
            if (!active || done)
                wait_cnt <= '0;     // next word starts over
            else
                wait_cnt <= wait_cnt + 8'd1;
            if (done && mem_req.wen) begin
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    if (mem_req.byte_en[b])
                        mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
cache_pkg.sv
cache_array.sv
block_counter.sv
cache_fsm.sv
cache_datapath.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv
